/* issue_stage.f */
rtl/ooo_pkg.sv
rtl/reg_read_if.sv
rtl/reservation_station.sv
rtl/issue_unit.sv
rtl/phys_regfile.sv
rtl/issue_stage_top.sv
bench/issue_stage_assert.sv
bench/issue_stage_tb.sv

/* bench/issue_stage_tb.sv */
`default_nettype none

module issue_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_alu     = 2;
    localparam int num_mult    = 1;
    localparam int num_ld      = 1;
    localparam int num_st      = 1;
    localparam int num_br      = 1;
    localparam int rs_size     = 8;
    localparam int num_fu      = num_alu + num_mult + num_ld + num_st + num_br;
    localparam int num_tags    = ooo_pkg::phys_regs;
    localparam int num_ids     = 1 << ooo_pkg::id_bits;
    localparam int num_cycles  = 2000;
    localparam int drain_limit = 400;

    logic                                clock;
    logic                                reset;
    logic                                dispatch_valid;
    ooo_pkg::rs_packet_t                 dispatch_packet;
    logic                                dispatch_t1_ready;
    logic                                dispatch_t2_ready;
    logic                                cdb_valid;
    ooo_pkg::phys_reg_t                  cdb_tag;
    ooo_pkg::data_t                      cdb_value;
    logic                                rs_full;
    logic [num_fu-1:0]                   fu_valid;
    ooo_pkg::issue_packet_t [num_fu-1:0] fu_packet;

    integer seed;

    // Reference model
    ooo_pkg::data_t      model_regs [num_tags];
    bit                  tag_ready [num_tags];
    bit                  pend_valid [num_ids];
    ooo_pkg::rs_packet_t pend_pkt [num_ids];
    ooo_pkg::rob_id_t    next_id;
    int                  burst_left;
    ooo_pkg::fu_class_t  burst_class;

    issue_stage_top dut0 (
        .clock             (clock),
        .reset             (reset),
        .dispatch_valid    (dispatch_valid),
        .dispatch_packet   (dispatch_packet),
        .dispatch_t1_ready (dispatch_t1_ready),
        .dispatch_t2_ready (dispatch_t2_ready),
        .cdb_valid         (cdb_valid),
        .cdb_tag           (cdb_tag),
        .cdb_value         (cdb_value),
        .rs_full           (rs_full),
        .fu_valid          (fu_valid),
        .fu_packet         (fu_packet)
    );

    always #20 clock = ~clock;

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // First slot of each class in the flat order
    function automatic int slot_base(input ooo_pkg::fu_class_t c);
        case (c)
            ooo_pkg::fu_alu:   return 0;
            ooo_pkg::fu_mult:  return num_alu;
            ooo_pkg::fu_load:  return num_alu + num_mult;
            ooo_pkg::fu_store: return num_alu + num_mult + num_ld;
            default:           return num_alu + num_mult + num_ld + num_st;
        endcase
    endfunction

    function automatic int slot_count(input ooo_pkg::fu_class_t c);
        case (c)
            ooo_pkg::fu_alu:   return num_alu;
            ooo_pkg::fu_mult:  return num_mult;
            ooo_pkg::fu_load:  return num_ld;
            ooo_pkg::fu_store: return num_st;
            default:           return num_br;
        endcase
    endfunction

    function automatic bit tag_in_use(input ooo_pkg::phys_reg_t t);
        for (int i = 0; i < num_ids; i++) begin
            if (pend_valid[i] && (pend_pkt[i].t1 == t || pend_pkt[i].t2 == t)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int i = 0; i < num_ids; i++) begin
            n = n + pend_valid[i];
        end
        return n;
    endfunction

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_data(input string name, input ooo_pkg::data_t got,
                              input ooo_pkg::data_t exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_tag(input string name, input ooo_pkg::phys_reg_t got,
                             input ooo_pkg::phys_reg_t exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_op(input string name, input logic [ooo_pkg::op_bits-1:0] got,
                            input logic [ooo_pkg::op_bits-1:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_class(input string name, input ooo_pkg::fu_class_t got,
                               input ooo_pkg::fu_class_t exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    // Compare every strobed slot against the waiting instruction with that id
    task automatic check_outputs();
        ooo_pkg::issue_packet_t p;
        ooo_pkg::rs_packet_t    e;
        int                     base;
        if ($isunknown(fu_valid)) begin
            report_failure("fu_valid has unknown bits");
        end
        for (int s = 0; s < num_fu; s++) begin
            if (fu_valid[s]) begin
                p = fu_packet[s];
                if ($isunknown(p.id) || !pend_valid[p.id]) begin
                    report_failure($sformatf("slot %0d issued id %0h that is not waiting",
                                             s, p.id));
                end
                e = pend_pkt[p.id];
                base = slot_base(e.fu);
                if (s < base || s >= base + slot_count(e.fu)) begin
                    report_failure($sformatf("id %0h issued in slot %0d outside its class",
                                             p.id, s));
                end
                if (!tag_ready[e.t1] || !tag_ready[e.t2]) begin
                    report_failure($sformatf("id %0h issued before its sources were ready",
                                             p.id));
                end
                check_class("fu_packet.fu", p.fu, e.fu);
                check_tag("fu_packet.dest", p.dest, e.dest);
                check_tag("fu_packet.t1", p.t1, e.t1);
                check_tag("fu_packet.t2", p.t2, e.t2);
                check_op("fu_packet.op", p.op, e.op);
                check_data("fu_packet.imm", p.imm, e.imm);
                check_data("fu_packet.rs1_value", p.rs1_value, model_regs[e.t1]);
                check_data("fu_packet.rs2_value", p.rs2_value, model_regs[e.t2]);
                pend_valid[p.id] = 1'b0;
            end
        end
        // Station now holds exactly the instructions still waiting
        check_flag("rs_full", rs_full, pending_count() == rs_size);
    endtask

    // One cycle of inputs; stim low means drain mode
    task automatic drive_cycle(input bit stim);
        ooo_pkg::rs_packet_t pkt;
        ooo_pkg::phys_reg_t  t;
        ooo_pkg::phys_reg_t  bt;
        logic [31:0]         word;
        bit                  bcast;
        dispatch_valid = 1'b0;
        cdb_valid = 1'b0;
        bcast = 1'b0;
        bt = '0;
        if (stim && rnd(2) == 0) begin
            t = ooo_pkg::phys_reg_t'(1 + rnd(num_tags - 1));
            if (tag_ready[t] && !tag_in_use(t)) begin
                tag_ready[t] = 1'b0;
            end
        end
        if (stim) begin
            t = ooo_pkg::phys_reg_t'(1 + rnd(num_tags - 1));
            if (rnd(2) == 0 && !tag_ready[t]) begin
                bt = t;
                bcast = 1'b1;
            end else if (rnd(16) == 0) begin
                // Tag 0 keeps reading zero whatever the broadcast carries
                bcast = 1'b1;
            end
        end else begin
            for (int r = num_tags - 1; r > 0; r--) begin
                if (!tag_ready[r]) begin
                    bt = ooo_pkg::phys_reg_t'(r);
                    bcast = 1'b1;
                end
            end
        end
        if (bcast) begin
            cdb_valid = 1'b1;
            cdb_tag = bt;
            cdb_value = $random(seed);
        end
        if (stim && burst_left == 0 && rnd(40) == 0) begin
            burst_left = 10;
            burst_class = (rnd(2) == 0) ? ooo_pkg::fu_alu : ooo_pkg::fu_class_t'(rnd(5));
        end
        if (stim && !rs_full && (burst_left > 0 || rnd(4) != 0)) begin
            pkt = '0;
            pkt.valid = 1'b1;
            pkt.fu = (burst_left > 0) ? burst_class : ooo_pkg::fu_class_t'(rnd(5));
            if (burst_left > 0) begin
                burst_left--;
            end
            for (int k = 0; k < num_ids && pend_valid[next_id]; k++) begin
                next_id++;
            end
            pkt.id = next_id;
            next_id++;
            pkt.dest = ooo_pkg::phys_reg_t'(rnd(num_tags));
            pkt.t1 = ooo_pkg::phys_reg_t'(rnd(num_tags));
            pkt.t2 = ooo_pkg::phys_reg_t'(rnd(num_tags));
            word = $random(seed);
            pkt.op = word[ooo_pkg::op_bits-1:0];
            pkt.imm = $random(seed);
            dispatch_valid = 1'b1;
            dispatch_packet = pkt;
            // Ready flags as seen before this cycle's broadcast
            dispatch_t1_ready = tag_ready[pkt.t1];
            dispatch_t2_ready = tag_ready[pkt.t2];
            pend_valid[pkt.id] = 1'b1;
            pend_pkt[pkt.id] = pkt;
        end
        if (bcast && bt != '0) begin
            tag_ready[bt] = 1'b1;
            model_regs[bt] = cdb_value;
        end
    endtask

    initial begin
        int waited;
        seed = 32'ha90c8f74;
        clock = 1'b0;
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_packet = '0;
        dispatch_t1_ready = 1'b0;
        dispatch_t2_ready = 1'b0;
        cdb_valid = 1'b0;
        cdb_tag = '0;
        cdb_value = '0;
        next_id = '0;
        burst_left = 0;
        burst_class = ooo_pkg::fu_alu;
        for (int r = 0; r < num_tags; r++) begin
            model_regs[r] = '0;
            tag_ready[r] = 1'b1;
        end
        for (int i = 0; i < num_ids; i++) begin
            pend_valid[i] = 1'b0;
            pend_pkt[i] = '0;
        end
        repeat (10) @(posedge clock);
        #2;
        reset = 1'b0;
        @(posedge clock);
        #2;
        if (fu_valid !== '0) begin
            report_failure("fu_valid set right after reset");
        end
        check_flag("rs_full", rs_full, 1'b0);
        for (int c = 0; c < num_cycles; c++) begin
            drive_cycle(1'b1);
            @(posedge clock);
            #2;
            check_outputs();
        end
        // Wake every waiting tag and let the station empty
        waited = 0;
        while (pending_count() != 0 && waited < drain_limit) begin
            drive_cycle(1'b0);
            @(posedge clock);
            #2;
            check_outputs();
            waited++;
        end
        dispatch_valid = 1'b0;
        cdb_valid = 1'b0;
        if (pending_count() != 0) begin
            $display("Timeout: %0d dispatched instructions never issued", pending_count());
            $display("CHECKS FAILED");
            $fatal(1, "drain timed out");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* bench/issue_stage_assert.sv */
`default_nettype none

module issue_stage_assert #(
    parameter int num_fu = 6
)(
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              dispatch_valid,
    input  wire logic              rs_full,
    input  wire logic [num_fu-1:0] fu_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // Empty station issues nothing in the first cycle out of reset
    valid_low_after_reset: assert property (@(posedge clock) $fell(reset) |=> fu_valid == '0)
        else $error("fu_valid not cleared in the cycle after reset");

    no_dispatch_when_full: assert property (@(posedge clock) disable iff (reset)
        !(dispatch_valid && rs_full))
        else $error("dispatch accepted while the station reports full");

    valid_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(fu_valid))
        else $error("fu_valid carries unknown bits");

endmodule

bind issue_stage_top issue_stage_assert #(.num_fu(num_fu)) assert0 (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .rs_full        (rs_full),
    .fu_valid       (fu_valid)
);

`default_nettype wire

/* rtl/issue_stage_top.sv */
`default_nettype none

module issue_stage_top #(
    parameter int num_alu  = 2,
    parameter int num_mult = 1,
    parameter int num_ld   = 1,
    parameter int num_st   = 1,
    parameter int num_br   = 1,
    parameter int rs_size  = 8,
    localparam int num_fu  = num_alu + num_mult + num_ld + num_st + num_br
)(
    input  wire logic                              clock,
    input  wire logic                              reset,

    input  wire logic                              dispatch_valid,
    input  wire ooo_pkg::rs_packet_t               dispatch_packet,
    input  wire logic                              dispatch_t1_ready,
    input  wire logic                              dispatch_t2_ready,

    input  wire logic                              cdb_valid,
    input  wire ooo_pkg::phys_reg_t                cdb_tag,
    input  wire ooo_pkg::data_t                    cdb_value,

    output logic                                   rs_full,
    output logic [num_fu-1:0]                      fu_valid,
    output ooo_pkg::issue_packet_t [num_fu-1:0]    fu_packet
);

    ooo_pkg::rs_packet_t [num_fu-1:0] selected;

    reg_read_if #(.num_fu(num_fu)) rd_bus ();

    reservation_station #(
        .num_alu  (num_alu),
        .num_mult (num_mult),
        .num_ld   (num_ld),
        .num_st   (num_st),
        .num_br   (num_br),
        .rs_size  (rs_size)
    ) rs0 (
        .clock             (clock),
        .reset             (reset),
        .dispatch_valid    (dispatch_valid),
        .dispatch_packet   (dispatch_packet),
        .dispatch_t1_ready (dispatch_t1_ready),
        .dispatch_t2_ready (dispatch_t2_ready),
        .cdb_valid         (cdb_valid),
        .cdb_tag           (cdb_tag),
        .rs_full           (rs_full),
        .selected          (selected)
    );

    issue_unit #(
        .num_alu  (num_alu),
        .num_mult (num_mult),
        .num_ld   (num_ld),
        .num_st   (num_st),
        .num_br   (num_br)
    ) issue0 (
        .clock     (clock),
        .reset     (reset),
        .selected  (selected),
        .rd        (rd_bus.requester),
        .fu_valid  (fu_valid),
        .fu_packet (fu_packet)
    );

    phys_regfile #(
        .num_fu (num_fu)
    ) prf0 (
        .clock     (clock),
        .reset     (reset),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .rd        (rd_bus.regfile)
    );

endmodule

`default_nettype wire

/* rtl/phys_regfile.sv */
`default_nettype none

module phys_regfile #(
    parameter int num_fu = 6
)(
    input  wire logic                  clock,
    input  wire logic                  reset,

    input  wire logic                  cdb_valid,
    input  wire ooo_pkg::phys_reg_t    cdb_tag,
    input  wire ooo_pkg::data_t        cdb_value,

    reg_read_if.regfile                rd
);

    ooo_pkg::data_t regs [ooo_pkg::phys_regs];

    logic write_en;

    // Tag 0 is hardwired to zero
    assign write_en = cdb_valid && (cdb_tag != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < ooo_pkg::phys_regs; r++) begin
                regs[r] <= '0;
            end
        end else if (write_en) begin
            regs[cdb_tag] <= cdb_value;
        end
    end

    // Reads see the stored contents only
    always_comb begin
        for (int s = 0; s < num_fu; s++) begin
            rd.data1[s] = regs[rd.idx1[s]];
            rd.data2[s] = regs[rd.idx2[s]];
        end
    end

endmodule

`default_nettype wire

/* rtl/issue_unit.sv */
`default_nettype none

module issue_unit #(
    parameter int num_alu  = 2,
    parameter int num_mult = 1,
    parameter int num_ld   = 1,
    parameter int num_st   = 1,
    parameter int num_br   = 1,
    localparam int num_fu  = num_alu + num_mult + num_ld + num_st + num_br
)(
    input  wire logic                                 clock,
    input  wire logic                                 reset,

    input  wire ooo_pkg::rs_packet_t [num_fu-1:0]     selected,

    reg_read_if.requester                             rd,

    output logic [num_fu-1:0]                         fu_valid,
    output ooo_pkg::issue_packet_t [num_fu-1:0]       fu_packet
);

    ooo_pkg::issue_packet_t [num_fu-1:0] next_packet;
    logic [num_fu-1:0]                   next_valid;

    // Slot s reads through port s
    always_comb begin
        for (int s = 0; s < num_fu; s++) begin
            rd.idx1[s] = selected[s].t1;
            rd.idx2[s] = selected[s].t2;
        end
    end

    always_comb begin
        for (int s = 0; s < num_fu; s++) begin
            next_valid[s] = selected[s].valid;

            next_packet[s].fu        = selected[s].fu;
            next_packet[s].id        = selected[s].id;
            next_packet[s].dest      = selected[s].dest;
            next_packet[s].t1        = selected[s].t1;
            next_packet[s].t2        = selected[s].t2;
            next_packet[s].op        = selected[s].op;
            next_packet[s].imm       = selected[s].imm;
            next_packet[s].rs1_value = rd.data1[s];
            next_packet[s].rs2_value = rd.data2[s];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            fu_valid <= '0;
        end else begin
            fu_valid <= next_valid;
        end
    end

    // Packet payload per slot
    always_ff @(posedge clock) begin
        fu_packet <= next_packet;
    end

endmodule

`default_nettype wire

/* rtl/reservation_station.sv */
`default_nettype none

module reservation_station #(
    parameter int num_alu  = 2,
    parameter int num_mult = 1,
    parameter int num_ld   = 1,
    parameter int num_st   = 1,
    parameter int num_br   = 1,
    parameter int rs_size  = 8,
    localparam int num_fu  = num_alu + num_mult + num_ld + num_st + num_br
)(
    input  wire logic                                clock,
    input  wire logic                                reset,

    input  wire logic                                dispatch_valid,
    input  wire ooo_pkg::rs_packet_t                 dispatch_packet,
    input  wire logic                                dispatch_t1_ready,
    input  wire logic                                dispatch_t2_ready,

    input  wire logic                                cdb_valid,
    input  wire ooo_pkg::phys_reg_t                  cdb_tag,

    output logic                                     rs_full,
    output ooo_pkg::rs_packet_t [num_fu-1:0]         selected
);

    localparam int idx_bits = (rs_size > 1) ? $clog2(rs_size) : 1;
    localparam int cnt_bits = $clog2(rs_size + 1);

    // Slot range of each class in the flat order
    localparam int class_count [ooo_pkg::num_classes] = '{
        num_alu, num_mult, num_ld, num_st, num_br
    };
    localparam int class_base [ooo_pkg::num_classes] = '{
        0,
        num_alu,
        num_alu + num_mult,
        num_alu + num_mult + num_ld,
        num_alu + num_mult + num_ld + num_st
    };

    ooo_pkg::rs_packet_t entries [rs_size];
    logic [rs_size-1:0]  t1_ready;
    logic [rs_size-1:0]  t2_ready;

    logic [rs_size-1:0]  entry_ready;
    logic [rs_size-1:0]  issue_now;

    logic                alloc_found;
    logic [idx_bits-1:0] alloc_idx;

    logic [cnt_bits-1:0] free_now;
    logic [cnt_bits-1:0] freed;
    logic [cnt_bits-1:0] next_free;

    logic                dispatch_wake1;
    logic                dispatch_wake2;

    always_comb begin
        for (int i = 0; i < rs_size; i++) begin
            entry_ready[i] = entries[i].valid && t1_ready[i] && t2_ready[i];
        end
    end

    // Lowest free entry wins
    always_comb begin
        alloc_found = 1'b0;
        alloc_idx = '0;
        for (int i = rs_size - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                alloc_found = 1'b1;
                alloc_idx = idx_bits'(i);
            end
        end
    end

    // Per class, ready entries fill the class slots in index order
    always_comb begin
        int filled;
        selected = '0;
        issue_now = '0;
        for (int c = 0; c < ooo_pkg::num_classes; c++) begin
            filled = 0;
            for (int i = 0; i < rs_size; i++) begin
                if (entry_ready[i] && entries[i].fu == ooo_pkg::fu_class_t'(c)
                        && filled < class_count[c]) begin
                    selected[class_base[c] + filled] = entries[i];
                    issue_now[i] = 1'b1;
                    filled = filled + 1;
                end
            end
        end
    end

    always_comb begin
        free_now = '0;
        freed = '0;
        for (int i = 0; i < rs_size; i++) begin
            if (!entries[i].valid) begin
                free_now = free_now + cnt_bits'(1);
            end
            if (issue_now[i]) begin
                freed = freed + cnt_bits'(1);
            end
        end
        next_free = free_now + freed;
        if (dispatch_valid && alloc_found) begin
            next_free = next_free - cnt_bits'(1);
        end
    end

    // A broadcast in the dispatch cycle counts as ready at allocation
    assign dispatch_wake1 = dispatch_t1_ready || (cdb_valid && cdb_tag == dispatch_packet.t1);
    assign dispatch_wake2 = dispatch_t2_ready || (cdb_valid && cdb_tag == dispatch_packet.t2);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rs_size; i++) begin
                entries[i].valid <= 1'b0;
            end
            rs_full <= 1'b0;
        end else begin
            for (int i = 0; i < rs_size; i++) begin
                if (cdb_valid && cdb_tag == entries[i].t1) begin
                    t1_ready[i] <= 1'b1;
                end
                if (cdb_valid && cdb_tag == entries[i].t2) begin
                    t2_ready[i] <= 1'b1;
                end
                if (issue_now[i]) begin
                    entries[i].valid <= 1'b0;
                end
            end
            if (dispatch_valid && alloc_found) begin
                entries[alloc_idx] <= dispatch_packet;
                entries[alloc_idx].valid <= 1'b1;
                t1_ready[alloc_idx] <= dispatch_wake1;
                t2_ready[alloc_idx] <= dispatch_wake2;
            end
            rs_full <= (next_free == '0);
        end
    end

endmodule

`default_nettype wire

/* rtl/reg_read_if.sv */
`default_nettype none

interface reg_read_if #(
    parameter int num_fu = 6
);

    // One pair of read ports per functional-unit slot
    ooo_pkg::phys_reg_t [num_fu-1:0] idx1;
    ooo_pkg::phys_reg_t [num_fu-1:0] idx2;
    ooo_pkg::data_t     [num_fu-1:0] data1;
    ooo_pkg::data_t     [num_fu-1:0] data2;

    modport requester (
        output idx1,
        output idx2,
        input  data1,
        input  data2
    );

    modport regfile (
        input  idx1,
        input  idx2,
        output data1,
        output data2
    );

endinterface

`default_nettype wire

/* rtl/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    localparam int xlen = 32;
    localparam int phys_regs = 64;
    localparam int tag_bits = $clog2(phys_regs);
    localparam int id_bits = 6;
    localparam int op_bits = 4;

    typedef logic [xlen-1:0] data_t;
    typedef logic [tag_bits-1:0] phys_reg_t;
    typedef logic [id_bits-1:0] rob_id_t;

    // Order matches the flat slot numbering
    typedef enum logic [2:0] {
        fu_alu    = 3'd0,
        fu_mult   = 3'd1,
        fu_load   = 3'd2,
        fu_store  = 3'd3,
        fu_branch = 3'd4
    } fu_class_t;

    localparam int num_classes = 5;

    // Instruction as held in the station
    typedef struct packed {
        logic               valid;
        fu_class_t          fu;
        rob_id_t            id;
        phys_reg_t          dest;
        phys_reg_t          t1;
        phys_reg_t          t2;
        logic [op_bits-1:0] op;
        data_t              imm;
    } rs_packet_t;

    // Instruction with operands, as sent to a functional unit
    typedef struct packed {
        fu_class_t          fu;
        rob_id_t            id;
        phys_reg_t          dest;
        phys_reg_t          t1;
        phys_reg_t          t2;
        logic [op_bits-1:0] op;
        data_t              imm;
        data_t              rs1_value;
        data_t              rs2_value;
    } issue_packet_t;

endpackage

`default_nettype wire
